// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_hps_io -f files.f -o tb_hps_io
	./obj_dir/tb_hps_io | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+verif
source/hps_pkg.sv
source/hps_word_if.sv
source/hps_frame_decoder.sv
source/hps_host_regs.sv
source/hps_file_loader.sv
source/ps2_kbd_emulator.sv
source/hps_io.sv
verif/tb_hps_io.sv

// ==== source/hps_file_loader.sv ====
`default_nettype none
`timescale 1ns/1ps

module hps_file_loader (
	input  wire                  clk_sys,
	input  wire                  reset,
	hps_word_if.rx               words,
	output logic                 ioctl_download,
	output hps_pkg::byte_t       ioctl_index,
	output logic [31:0]          ioctl_file_ext,
	output logic                 ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::byte_t       ioctl_dout
);

	// address of the next data byte
	hps_pkg::ioctl_addr_t next_addr;

	logic arg_word;

	assign arg_word = words.word_valid && (words.word_idx != '0);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			next_addr      <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (arg_word) begin
				case (words.cmd)
					// extension arrives high word first
					hps_pkg::cmd_file_info: begin
						if (words.word_idx == 10'd1) ioctl_file_ext[31:16] <= words.data;
						if (words.word_idx == 10'd2) ioctl_file_ext[15:0] <= words.data;
					end
					hps_pkg::cmd_file_index: begin
						if (words.word_idx == 10'd1) ioctl_index <= words.data[7:0];
					end
					hps_pkg::cmd_file_tx: begin
						if (words.data[7:0] != 8'h00) begin
							next_addr      <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// final byte count stays visible to the core
							ioctl_addr     <= next_addr;
							ioctl_download <= 1'b0;
						end
					end
					hps_pkg::cmd_file_dat: begin
						ioctl_addr <= next_addr;
						ioctl_dout <= words.data[7:0];
						ioctl_wr   <= 1'b1;
						next_addr  <= next_addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	a_wr_in_download : assert property (
		@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download
	);

endmodule

`default_nettype wire

// ==== source/hps_frame_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module hps_frame_decoder (
	input  wire                clk_sys,
	input  wire                reset,
	input  wire                io_enable,
	input  wire                io_strobe,
	input  hps_pkg::hps_word_t io_din,
	hps_word_if.tx             words
);

	// strobes seen so far in this frame
	hps_pkg::word_idx_t idx_cnt;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			idx_cnt            <= '0;
			words.frame_active <= 1'b0;
			words.frame_end    <= 1'b0;
			words.word_valid   <= 1'b0;
			words.word_idx     <= '0;
			words.data         <= '0;
			words.cmd          <= hps_pkg::hps_cmd_e'(16'h0000);
		end else begin
			words.frame_active <= io_enable;
			words.frame_end    <= words.frame_active & ~io_enable;
			words.word_valid   <= 1'b0;

			if (!io_enable) begin
				idx_cnt <= '0;
			end else if (io_strobe) begin
				words.word_valid <= 1'b1;
				words.word_idx   <= idx_cnt;
				words.data       <= io_din;
				// cmd stays latched past frame_end for the units
				if (idx_cnt == '0) begin
					words.cmd <= hps_pkg::hps_cmd_e'(io_din);
				end
				if (idx_cnt != '1) begin
					idx_cnt <= idx_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////
	// checks
	////////////////////////////////

	// one published word per host strobe
	a_word_pulse : assert property (
		@(posedge clk_sys) disable iff (reset)
		words.word_valid |=> !words.word_valid
	);

endmodule

`default_nettype wire

// ==== source/hps_host_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module hps_host_regs (
	input  wire                 clk_sys,
	input  wire                 reset,
	hps_word_if.rx              words,
	output hps_pkg::hps_word_t  io_dout,
	output wire  [1:0]          buttons,
	output wire                 forced_scandoubler,
	output wire                 direct_video,
	output hps_pkg::joy_t       joystick_0,
	output hps_pkg::joy_t       joystick_1,
	output hps_pkg::status_t    status,
	input  hps_pkg::status_t    status_in,
	input  wire                 status_set
);

	hps_pkg::hps_word_t cfg;

	// core-initiated status request
	logic               status_set_q;
	logic [3:0]         set_cnt;
	hps_pkg::status_t   status_req;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_q <= 1'b0;
			set_cnt      <= '0;
			status_req   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				set_cnt    <= set_cnt + 1'b1;
				status_req <= status_in;
			end
		end
	end

	////////////////////////////////
	// host writes
	////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (words.word_valid && words.word_idx != '0) begin
			case (words.cmd)
				hps_pkg::cmd_cfg: cfg <= words.data;
				hps_pkg::cmd_joy0: begin
					if (words.word_idx == 10'd1) joystick_0[15:0] <= words.data;
					if (words.word_idx == 10'd2) joystick_0[31:16] <= words.data;
				end
				hps_pkg::cmd_joy1: begin
					if (words.word_idx == 10'd1) joystick_1[15:0] <= words.data;
					if (words.word_idx == 10'd2) joystick_1[31:16] <= words.data;
				end
				// least significant word first
				hps_pkg::cmd_status: begin
					case (words.word_idx)
						10'd1: status[15:0] <= words.data;
						10'd2: status[31:16] <= words.data;
						10'd3: status[47:32] <= words.data;
						10'd4: status[63:48] <= words.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////
	// read response
	////////////////////////////////

	// word n loads the answer for word n+1
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (words.frame_end) begin
			io_dout <= '0;
		end else if (words.word_valid) begin
			io_dout <= '0;
			if (words.cmd == hps_pkg::cmd_status_set) begin
				case (words.word_idx)
					10'd0: io_dout <= {8'h00, hps_pkg::status_set_tag, set_cnt};
					10'd1: io_dout <= status_req[15:0];
					10'd2: io_dout <= status_req[31:16];
					10'd3: io_dout <= status_req[47:32];
					10'd4: io_dout <= status_req[63:48];
					default: ;
				endcase
			end
		end
	end

	a_dout_idle : assert property (
		@(posedge clk_sys) disable iff (reset)
		(!words.frame_active && !words.frame_end) |-> (io_dout == '0)
	);

endmodule

`default_nettype wire

// ==== source/hps_io.sv ====
`default_nettype none
`timescale 1ns/1ps

module hps_io #(
	parameter int ps2_div   = 4,
	parameter int fifo_bits = 5
) (
	input  wire                  clk_sys,
	input  wire                  reset,

	// host bus
	input  wire                  io_enable,
	input  wire                  io_strobe,
	input  hps_pkg::hps_word_t   io_din,
	output hps_pkg::hps_word_t   io_dout,
	output wire                  io_wait,

	// configuration, joysticks and status
	output wire  [1:0]           buttons,
	output wire                  forced_scandoubler,
	output wire                  direct_video,
	output hps_pkg::joy_t        joystick_0,
	output hps_pkg::joy_t        joystick_1,
	output hps_pkg::status_t     status,
	input  hps_pkg::status_t     status_in,
	input  wire                  status_set,

	// download
	output wire                  ioctl_download,
	output hps_pkg::byte_t       ioctl_index,
	output wire  [31:0]          ioctl_file_ext,
	output wire                  ioctl_wr,
	output hps_pkg::ioctl_addr_t ioctl_addr,
	output hps_pkg::byte_t       ioctl_dout,
	input  wire                  ioctl_wait,

	// keyboard
	output wire                  ps2_kbd_clk_out,
	output wire                  ps2_kbd_data_out,
	output hps_pkg::ps2_key_t    ps2_key
);

	// the host itself holds off strobes under back-pressure
	assign io_wait = ioctl_wait;

	hps_word_if words ();

	hps_frame_decoder u_decoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.words     (words.tx)
	);

	hps_host_regs u_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.words              (words.rx),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set)
	);

	hps_file_loader u_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.words          (words.rx),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	ps2_kbd_emulator #(
		.ps2_div   (ps2_div),
		.fifo_bits (fifo_bits)
	) u_kbd (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.words            (words.rx),
		.ps2_kbd_clk_out  (ps2_kbd_clk_out),
		.ps2_kbd_data_out (ps2_kbd_data_out),
		.ps2_key          (ps2_key)
	);

endmodule

`default_nettype wire

// ==== source/hps_pkg.sv ====
`default_nettype none

package hps_pkg;

	////////////////////////////////
	// bus and payload widths
	////////////////////////////////

	typedef logic [15:0] hps_word_t;
	typedef logic [7:0]  byte_t;

	// word position in a frame, 0 is the command word
	typedef logic [9:0]  word_idx_t;

	typedef logic [31:0] joy_t;
	typedef logic [63:0] status_t;
	typedef logic [26:0] ioctl_addr_t;

	// [10] toggle, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] ps2_key_t;

	////////////////////////////////
	// command codes
	////////////////////////////////

	typedef enum logic [15:0] {
		cmd_cfg        = 16'h0001,
		cmd_joy0       = 16'h0002,
		cmd_joy1       = 16'h0003,
		cmd_ps2_kbd    = 16'h0005,
		cmd_status     = 16'h001e,
		cmd_status_set = 16'h0029,
		cmd_file_tx    = 16'h0053,
		cmd_file_dat   = 16'h0054,
		cmd_file_index = 16'h0055,
		cmd_file_info  = 16'h0056
	} hps_cmd_e;

	// state names tell which bit is on the data line
	typedef enum logic [2:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_parity,
		tx_stop
	} ps2_tx_state_e;

	// upper nibble of the status-set response
	localparam logic [3:0] status_set_tag = 4'hA;

	// upper byte that cancels the rest of a keyboard frame
	localparam byte_t ps2_skip_mark = 8'hFF;

endpackage

`default_nettype wire

// ==== source/hps_word_if.sv ====
`default_nettype none
`timescale 1ns/1ps

interface hps_word_if;

	logic                 frame_active;
	logic                 word_valid;
	hps_pkg::hps_cmd_e    cmd;
	hps_pkg::word_idx_t   word_idx;
	hps_pkg::hps_word_t   data;
	logic                 frame_end;

	// driven by the frame decoder
	modport tx (output frame_active, word_valid, cmd, word_idx, data, frame_end);

	// function units only sample, on word_valid or frame_end
	modport rx (input frame_active, word_valid, cmd, word_idx, data, frame_end);

endinterface

`default_nettype wire

// ==== source/ps2_kbd_emulator.sv ====
`default_nettype none
`timescale 1ns/1ps

module ps2_kbd_emulator #(
	parameter int ps2_div   = 4,
	parameter int fifo_bits = 5
) (
	input  wire               clk_sys,
	input  wire               reset,
	hps_word_if.rx            words,
	output logic              ps2_kbd_clk_out,
	output logic              ps2_kbd_data_out,
	output hps_pkg::ps2_key_t ps2_key
);

	localparam int div_bits = $clog2(ps2_div + 1);

	////////////////////////////////
	// host side
	////////////////////////////////

	logic        kbd_frame;
	logic        skip;
	logic [31:0] raw;
	logic        take;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	assign take = words.word_valid && kbd_frame && (words.word_idx != '0) && !skip
		&& (words.data[15:8] != hps_pkg::ps2_skip_mark);

	// a release is prefixed by F0, an extended key by E0 before that
	always_comb begin
		pressed  = raw[15:8] != 8'hF0;
		extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		key_code = {pressed, extended, raw[7:0]};
		case (raw)
			32'hE012E07C: key_code = 10'h37C;
			32'h7CE0F012: key_code = 10'h17C;
			32'hF014F077: key_code = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			kbd_frame <= 1'b0;
			skip      <= 1'b0;
			raw       <= '0;
			ps2_key   <= '0;
		end else if (words.frame_end) begin
			if (kbd_frame && !skip) begin
				ps2_key <= {~ps2_key[10], key_code};
			end
			kbd_frame <= 1'b0;
		end else if (words.word_valid) begin
			if (words.word_idx == '0) begin
				kbd_frame <= words.cmd == hps_pkg::cmd_ps2_kbd;
				skip      <= 1'b0;
				raw       <= '0;
			end else if (kbd_frame && words.data[15:8] == hps_pkg::ps2_skip_mark) begin
				skip <= 1'b1;
			end
			if (take) begin
				raw <= {raw[23:0], words.data[7:0]};
			end
		end
	end

	////////////////////////////////
	// byte FIFO
	////////////////////////////////

	hps_pkg::byte_t       fifo_mem [2**fifo_bits];
	logic [fifo_bits:0]   wptr;
	logic [fifo_bits:0]   rptr;
	logic                 fifo_empty;
	logic                 fifo_full;
	logic                 fifo_we;

	assign fifo_empty = wptr == rptr;
	assign fifo_full  = (wptr[fifo_bits] != rptr[fifo_bits])
		&& (wptr[fifo_bits-1:0] == rptr[fifo_bits-1:0]);
	// newest byte is lost on overflow
	assign fifo_we    = take && !fifo_full;

	always_ff @(posedge clk_sys) begin
		if (fifo_we) fifo_mem[wptr[fifo_bits-1:0]] <= words.data[7:0];
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) wptr <= '0;
		else if (fifo_we) wptr <= wptr + 1'b1;
	end

	////////////////////////////////
	// PS/2 clock and transmitter
	////////////////////////////////

	logic [div_bits-1:0]    div_cnt;
	logic                   clk_ps2;
	logic                   div_tc;
	logic                   ps2_rise;
	logic                   ps2_fall;
	hps_pkg::ps2_tx_state_e tx_state;
	hps_pkg::byte_t         tx_shift;
	logic [2:0]             bit_cnt;
	logic                   parity;
	logic [1:0]             idle_cnt;

	assign div_tc   = div_cnt == div_bits'(ps2_div - 1);
	assign ps2_rise = div_tc && !clk_ps2;
	assign ps2_fall = div_tc && clk_ps2;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt <= '0;
			clk_ps2 <= 1'b0;
		end else if (div_tc) begin
			div_cnt <= '0;
			clk_ps2 <= ~clk_ps2;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// data changes on the rising phase, the host samples on the falling one
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			tx_state         <= hps_pkg::tx_idle;
			tx_shift         <= '0;
			bit_cnt          <= '0;
			parity           <= 1'b1;
			idle_cnt         <= '0;
			rptr             <= '0;
			ps2_kbd_data_out <= 1'b1;
			ps2_kbd_clk_out  <= 1'b1;
		end else begin
			if (ps2_fall) ps2_kbd_clk_out <= tx_state == hps_pkg::tx_idle;
			if (ps2_rise) begin
				ps2_kbd_clk_out <= 1'b1;
				case (tx_state)
					hps_pkg::tx_idle: begin
						if (idle_cnt != '0) begin
							idle_cnt <= idle_cnt - 1'b1;
						end else if (!fifo_empty) begin
							tx_shift         <= fifo_mem[rptr[fifo_bits-1:0]];
							rptr             <= rptr + 1'b1;
							parity           <= 1'b1;
							ps2_kbd_data_out <= 1'b0;
							tx_state         <= hps_pkg::tx_start;
						end
					end
					hps_pkg::tx_start, hps_pkg::tx_data: begin
						if (tx_state == hps_pkg::tx_data && bit_cnt == 3'd7) begin
							ps2_kbd_data_out <= parity;
							tx_state         <= hps_pkg::tx_parity;
						end else begin
							ps2_kbd_data_out <= tx_shift[0];
							tx_shift         <= {1'b0, tx_shift[7:1]};
							parity           <= parity ^ tx_shift[0];
							bit_cnt          <= (tx_state == hps_pkg::tx_start)
								? 3'd0 : bit_cnt + 1'b1;
							tx_state         <= hps_pkg::tx_data;
						end
					end
					hps_pkg::tx_parity: begin
						ps2_kbd_data_out <= 1'b1;
						tx_state         <= hps_pkg::tx_stop;
					end
					default: begin
						idle_cnt <= 2'd2;
						tx_state <= hps_pkg::tx_idle;
					end
				endcase
			end
		end
	end

	// occupancy never goes past the FIFO depth
	a_no_write_full : assert property (
		@(posedge clk_sys) disable iff (reset)
		(wptr - rptr) <= (fifo_bits + 1)'(2**fifo_bits)
	);

endmodule

`default_nettype wire

// ==== verif/tb_hps_tasks.svh ====
`ifndef TB_HPS_TASKS_SVH
`define TB_HPS_TASKS_SVH

//////////////////////////////
// reference model state
//////////////////////////////

hps_pkg::hps_word_t frame_words [0:63];
hps_pkg::hps_word_t frame_resp  [0:64];

hps_pkg::hps_word_t exp_cfg      = '0;
hps_pkg::joy_t      exp_joy0     = '0;
hps_pkg::joy_t      exp_joy1     = '0;
hps_pkg::status_t   exp_status   = '0;
hps_pkg::status_t   exp_captured = '0;
int                 set_pulses   = 0;
logic               exp_toggle   = 1'b0;

// download bytes in the order they were sent
hps_pkg::byte_t     dl_bytes [0:63];
int                 wr_count     = 0;

// keyboard bytes of the current frame, and bytes still owed on the serial line
hps_pkg::byte_t     kbd_seq [$];
hps_pkg::byte_t     kbd_expect [$];
int                 sent_count   = 0;
int                 rx_count     = 0;

function automatic logic [31:0] rand32();
	return $random(seed);
endfunction

//////////////////////////////
// bus driver
//////////////////////////////

// one strobe every 4 cycles, each response sampled as the next strobe is driven
task automatic send_frame(input int len);
	int i;
	@(posedge clk_sys);
	#1;
	io_enable = 1'b1;
	for (i = 0; i < len; i++) begin
		while (io_wait) begin
			@(posedge clk_sys);
			#1;
		end
		frame_resp[i] = io_dout;
		io_din        = frame_words[i];
		io_strobe     = 1'b1;
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
	end
	frame_resp[len] = io_dout;
	io_enable       = 1'b0;
	// frame_end and the updates that follow it
	repeat (4) @(posedge clk_sys);
	#1;
endtask

task automatic pulse_status_set();
	logic [31:0] hi;
	logic [31:0] lo;
	hi           = rand32();
	lo           = rand32();
	status_in    = {hi, lo};
	status_set   = 1'b1;
	exp_captured = {hi, lo};
	set_pulses   = set_pulses + 1;
	@(posedge clk_sys);
	#1;
	status_set = 1'b0;
	@(posedge clk_sys);
	#1;
endtask

// bytes are packed most significant first
task automatic load_seq(input logic [63:0] bytes, input int n);
	int i;
	kbd_seq.delete();
	for (i = 0; i < n; i++) begin
		kbd_seq.push_back(bytes[8*(n-1-i) +: 8]);
	end
endtask

// F0 before the code is a release, an E0 at the front marks an extended key
function automatic hps_pkg::ps2_key_t expected_key(input logic toggle);
	int   n;
	logic released;
	logic extended;
	n        = kbd_seq.size();
	released = (n > 1) && (kbd_seq[n-2] == 8'hF0);
	extended = kbd_seq[0] == 8'hE0;
	return {toggle, !released, extended, kbd_seq[n-1]};
endfunction

//////////////////////////////
// typed compares
//////////////////////////////

task automatic check_word(input string name, input hps_pkg::hps_word_t exp,
		input hps_pkg::hps_word_t act);
	if (act !== exp) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_joy(input string name, input hps_pkg::joy_t exp,
		input hps_pkg::joy_t act);
	if (act !== exp) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_status(input string name, input hps_pkg::status_t exp,
		input hps_pkg::status_t act);
	if (act !== exp) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_addr(input string name, input hps_pkg::ioctl_addr_t exp,
		input hps_pkg::ioctl_addr_t act);
	if (act !== exp) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_byte(input string name, input hps_pkg::byte_t exp,
		input hps_pkg::byte_t act);
	if (act !== exp) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_key(input string name, input hps_pkg::ps2_key_t exp,
		input hps_pkg::ps2_key_t act);
	if (act !== exp) fail_now($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
endtask

`endif

// ==== verif/tb_hps_io.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_hps_io;

	logic                 clk_sys;
	logic                 reset;
	logic                 io_enable;
	logic                 io_strobe;
	hps_pkg::hps_word_t   io_din;
	hps_pkg::hps_word_t   io_dout;
	logic                 io_wait;
	logic [1:0]           buttons;
	logic                 forced_scandoubler;
	logic                 direct_video;
	hps_pkg::joy_t        joystick_0;
	hps_pkg::joy_t        joystick_1;
	hps_pkg::status_t     status;
	hps_pkg::status_t     status_in;
	logic                 status_set;
	logic                 ioctl_download;
	hps_pkg::byte_t       ioctl_index;
	logic [31:0]          ioctl_file_ext;
	logic                 ioctl_wr;
	hps_pkg::ioctl_addr_t ioctl_addr;
	hps_pkg::byte_t       ioctl_dout;
	logic                 ioctl_wait;
	logic                 ps2_kbd_clk_out;
	logic                 ps2_kbd_data_out;
	hps_pkg::ps2_key_t    ps2_key;

	integer      seed;
	int          cycles   = 0;
	logic [10:0] rx_frame = '0;
	int          rx_bits  = 0;

	hps_io #(.ps2_div(4), .fifo_bits(5)) dut (.*);

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_hps_tasks.svh"

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// frames and about 36 PS/2 bytes need well under half of this
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= 20000) fail_now("timeout: the run went past 20000 clock cycles");
	end

	// every write strobe against the byte sent at that position
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			check_addr("download address", hps_pkg::ioctl_addr_t'(wr_count), ioctl_addr);
			check_byte("download data", dl_bytes[wr_count], ioctl_dout);
			wr_count = wr_count + 1;
		end
	end

	// one PS/2 frame is 11 bits taken on falling clock edges
	always @(negedge ps2_kbd_clk_out) begin
		rx_frame = {ps2_kbd_data_out, rx_frame[10:1]};
		rx_bits  = rx_bits + 1;
		if (rx_bits == 11) begin
			rx_bits = 0;
			if (rx_frame[0] !== 1'b0 || rx_frame[10] !== 1'b1)
				fail_now("PS/2 frame with a bad start or stop bit");
			if (^rx_frame[9:1] !== 1'b1)
				fail_now("PS/2 frame with even parity");
			if (kbd_expect.size() == 0)
				fail_now("PS/2 byte sent that the host never queued");
			check_byte("ps2 serial byte", kbd_expect.pop_front(), rx_frame[8:1]);
			rx_count = rx_count + 1;
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_config();
		logic [31:0]        r;
		hps_pkg::hps_word_t act;
		repeat (20) begin
			r              = rand32();
			exp_cfg        = r[15:0];
			frame_words[0] = hps_pkg::cmd_cfg;
			frame_words[1] = exp_cfg;
			send_frame(2);
			act = {5'b0, direct_video, 5'b0, forced_scandoubler, 2'b0, buttons};
			check_word("config bits", exp_cfg & 16'h0413, act);
		end
	endtask

	task automatic test_joy_status();
		repeat (10) begin
			exp_joy0       = rand32();
			frame_words[0] = hps_pkg::cmd_joy0;
			frame_words[1] = exp_joy0[15:0];
			frame_words[2] = exp_joy0[31:16];
			send_frame(3);
			exp_joy1       = rand32();
			frame_words[0] = hps_pkg::cmd_joy1;
			frame_words[1] = exp_joy1[15:0];
			frame_words[2] = exp_joy1[31:16];
			send_frame(3);
			check_joy("joystick 0", exp_joy0, joystick_0);
			check_joy("joystick 1", exp_joy1, joystick_1);
			exp_status     = {rand32(), rand32()};
			frame_words[0] = hps_pkg::cmd_status;
			frame_words[1] = exp_status[15:0];
			frame_words[2] = exp_status[31:16];
			frame_words[3] = exp_status[47:32];
			frame_words[4] = exp_status[63:48];
			send_frame(5);
			check_status("status", exp_status, status);
		end
	endtask

	task automatic test_status_set();
		int k;
		int i;
		repeat (4) begin
			k = rand32() & 32'd31;
			repeat (k) pulse_status_set();
			frame_words[0] = hps_pkg::cmd_status_set;
			for (i = 1; i < 6; i++) frame_words[i] = '0;
			send_frame(6);
			check_word("status-set tag", 16'h00A0 | 16'(set_pulses % 16), frame_resp[1]);
			for (i = 0; i < 4; i++) begin
				check_word("status-set word", exp_captured[16*i +: 16], frame_resp[i+2]);
			end
			check_word("io_dout after frame", '0, io_dout);
		end
	endtask

	task automatic test_download();
		logic [31:0] r;
		logic [31:0] ext;
		int          n;
		int          i;
		n              = 24;
		r              = rand32();
		ext            = rand32();
		frame_words[0] = hps_pkg::cmd_file_index;
		frame_words[1] = r[15:0];
		send_frame(2);
		frame_words[0] = hps_pkg::cmd_file_info;
		frame_words[1] = ext[31:16];
		frame_words[2] = ext[15:0];
		send_frame(3);
		check_byte("file index", r[7:0], ioctl_index);
		check_word("file extension high", ext[31:16], ioctl_file_ext[31:16]);
		check_word("file extension low", ext[15:0], ioctl_file_ext[15:0]);

		// back-pressure goes straight to the host
		ioctl_wait = 1'b1;
		@(posedge clk_sys);
		#1;
		if (io_wait !== 1'b1) fail_now("io_wait does not follow ioctl_wait");
		ioctl_wait = 1'b0;

		wr_count       = 0;
		frame_words[0] = hps_pkg::cmd_file_tx;
		frame_words[1] = 16'h00ff;
		send_frame(2);
		if (ioctl_download !== 1'b1) fail_now("ioctl_download did not rise on the start frame");
		frame_words[0] = hps_pkg::cmd_file_dat;
		for (i = 0; i < n; i++) begin
			r                = rand32();
			dl_bytes[i]      = r[7:0];
			frame_words[i+1] = r[15:0];
		end
		send_frame(n + 1);
		if (wr_count != n) fail_now($sformatf("%0d write strobes for %0d bytes", wr_count, n));
		frame_words[1] = 16'h0000;
		frame_words[0] = hps_pkg::cmd_file_tx;
		send_frame(2);
		if (ioctl_download !== 1'b0) fail_now("ioctl_download stayed high after the stop frame");
		check_addr("final address", hps_pkg::ioctl_addr_t'(n), ioctl_addr);
	endtask

	task automatic test_keyboard();
		logic [31:0]       r;
		hps_pkg::ps2_key_t exp;
		int                ev;
		int                i;
		for (ev = 0; ev < 12; ev++) begin
			r = rand32();
			case (ev)
				5: load_seq(64'hE012E07C, 4);
				8: load_seq(64'hE0F07CE0F012, 6);
				11: load_seq(64'hE11477E1F014F077, 8);
				default: begin
					kbd_seq.delete();
					if (r[8]) kbd_seq.push_back(8'hE0);
					if (r[9]) kbd_seq.push_back(8'hF0);
					kbd_seq.push_back({1'b0, r[6:0]});
				end
			endcase
			exp_toggle = ~exp_toggle;
			case (ev)
				5: exp = {exp_toggle, 10'h37C};
				8: exp = {exp_toggle, 10'h17C};
				11: exp = {exp_toggle, 10'h377};
				default: exp = expected_key(exp_toggle);
			endcase
			frame_words[0] = hps_pkg::cmd_ps2_kbd;
			for (i = 0; i < kbd_seq.size(); i++) begin
				frame_words[i+1] = {8'h00, kbd_seq[i]};
				kbd_expect.push_back(kbd_seq[i]);
			end
			sent_count = sent_count + kbd_seq.size();
			send_frame(kbd_seq.size() + 1);
			check_key("key event", exp, ps2_key);
			wait (rx_count == sent_count);
		end
	endtask

	initial begin
		seed       = 32'h73e1_bef1;
		reset      = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		test_config();
		test_joy_status();
		test_status_set();
		test_download();
		test_keyboard();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
